//--- vlog.f
hdl/rg_pkg.sv
hdl/rg_bus_decode.sv
hdl/rg_sound_pair.sv
hdl/rg_video_timer.sv
hdl/rg_game.sv
test/rg_game_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary -Wno-fatal --top-module rg_game_tb -f vlog.f -o rg_game_sim \
    && ./obj_dir/rg_game_sim \
    || exit 1

//--- test/rg_game_tb.sv
// ----------------------------------------------------------
// Testbench for the game glue top level
// LFSR stimulus, reference model of decode, mailbox and
// video timer, output compare and cycle timeout
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module rg_game_tb import rg_pkg::*; ();

    localparam int CEN_DIV  = 2;
    localparam int H_TOTAL  = 16;
    localparam int H_VIS    = 12;
    localparam int HS_START = 13;
    localparam int HS_LEN   = 2;
    localparam int V_TOTAL  = 10;
    localparam int V_VIS    = 8;
    localparam int VS_START = 8;
    localparam int VS_LEN   = 1;
    localparam int FRAME    = CEN_DIV * H_TOTAL * V_TOTAL;
    localparam int DEC_LEN  = 300;
    localparam int SND_LEN  = 300;
    localparam int HOLD_LEN = 4 * 8;
    localparam int LINE_LEN = 4 * FRAME;
    localparam int LIMIT    = 4 * (DEC_LEN + SND_LEN + HOLD_LEN + 2 * FRAME + LINE_LEN + 8);

    logic        clk48 = 1'b0;
    logic        arst_n;
    logic [23:1] cpu_addr;
    logic [15:0] cpu_dout;
    logic        cpu_rnw;
    logic [1:0]  cpu_dsn;
    logic        cpu_as;
    logic        rom_cs;
    logic        ram_cs;
    logic [1:0]  ram_we;
    logic        ram_ok;
    logic [7:0]  mmr_dout;
    logic        snd_addr;
    logic        snd_rd;
    logic        snd_we;
    logic [7:0]  snd_din;
    logic [7:0]  snd_dout;
    logic        snd_irq;
    logic        pxl_cen;
    logic [8:0]  hdump;
    logic [8:0]  vdump;
    logic        lhbl;
    logic        lvbl;
    logic        hs;
    logic        vs;
    logic        line_irq;

    // Reference model state
    int          m_cen;
    int          m_h;
    int          m_v;
    logic        m_pxl;
    logic        m_lhbl;
    logic        m_lvbl;
    logic        m_hs;
    logic        m_vs;
    logic        m_irq;
    logic [7:0]  m_line;
    logic        m_as_l;
    logic        m_ram_ok;
    logic [7:0]  m_latch [2];
    logic [7:0]  m_reply;
    logic        m_snd_irq;

    logic [15:0] lfsr;
    int          cycles = 0;
    int          cen_gap;
    logic        gap_valid;

    rg_game #(
        .CEN_DIV  ( CEN_DIV  ),
        .H_TOTAL  ( H_TOTAL  ),
        .H_VIS    ( H_VIS    ),
        .HS_START ( HS_START ),
        .HS_LEN   ( HS_LEN   ),
        .V_TOTAL  ( V_TOTAL  ),
        .V_VIS    ( V_VIS    ),
        .VS_START ( VS_START ),
        .VS_LEN   ( VS_LEN   )
    ) dut0 (.*);

    always #4 clk48 = ~clk48;

    always @(posedge clk48) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: the run went past %0d clock cycles", LIMIT);
            $display("Errors found");
            $fatal(1, "simulation stopped by timeout");
        end
    end

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic rand_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] v;
        for (int i = 0; i < 8; i++) begin
            v = {v[6:0], rand_bit()};
        end
        return v;
    endfunction

    // Mostly pages that hit a region and sometimes any page
    function automatic logic [7:0] rand_page();
        logic [2:0] sel;
        sel = {rand_bit(), rand_bit(), rand_bit()};
        case (sel)
            3'd0, 3'd1: return {3'b000, rand_bit(), rand_bit(), rand_bit(), rand_bit(), rand_bit()};
            3'd2:       return RAM_PAGE;
            3'd3:       return VTIM_PAGE;
            3'd4:       return PAIR_PAGE;
            default:    return rand_byte();
        endcase
    endfunction

    function automatic region_t region_of(input logic [7:0] page);
        if (page <= ROM_TOP) return REG_ROM;
        if (page == RAM_PAGE) return REG_RAM;
        if (page == VTIM_PAGE) return REG_VTIM;
        if (page == PAIR_PAGE) return REG_PAIR;
        return REG_NONE;
    endfunction

    task automatic compare(input string name, input int exp_v, input int act_v);
        if (exp_v != act_v) begin
            $display("error: %s expected %0h actual %0h", name, exp_v, act_v);
            $display("Errors found");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // Advance the model by one clk48 edge using the inputs seen at that edge
    task automatic model_edge();
        region_t r;
        logic    wr;
        logic    hit;
        int      hn;
        int      vn;
        r   = region_of(cpu_addr[23:16]);
        wr  = cpu_as && !m_as_l && !cpu_rnw && !cpu_dsn[1];
        hit = 1'b0;
        if (wr && r == REG_PAIR) begin
            m_latch[cpu_addr[1]] = cpu_dout[15:8];
        end
        if (wr && r == REG_PAIR && !cpu_addr[1]) begin
            m_snd_irq = 1'b1;
        end else if (snd_rd && !snd_addr) begin
            m_snd_irq = 1'b0;
        end
        if (snd_we) begin
            m_reply = snd_din;
        end
        if (m_pxl) begin
            hn = (m_h == H_TOTAL - 1) ? 0 : m_h + 1;
            vn = m_v;
            if (hn == 0) begin
                vn = (m_v == V_TOTAL - 1) ? 0 : m_v + 1;
            end
            hit    = vn != m_v && vn == int'(m_line);
            m_h    = hn;
            m_v    = vn;
            m_lhbl = m_h < H_VIS;
            m_lvbl = m_v < V_VIS;
            m_hs   = m_h >= HS_START && m_h < HS_START + HS_LEN;
            m_vs   = m_v >= VS_START && m_v < VS_START + VS_LEN;
        end
        if (hit) begin
            m_irq = 1'b1;
        end else if (wr && r == REG_VTIM && cpu_addr[1] == VTIM_OFS_ACK) begin
            m_irq = 1'b0;
        end
        if (wr && r == REG_VTIM && cpu_addr[1] == VTIM_OFS_LINE) begin
            m_line = cpu_dout[15:8];
        end
        m_pxl    = m_cen == CEN_DIV - 1;
        m_cen    = (m_cen == CEN_DIV - 1) ? 0 : m_cen + 1;
        m_ram_ok = cpu_as && r == REG_RAM;
        m_as_l   = cpu_as;
    endtask

    task automatic tick();
        @(posedge clk48);
        model_edge();
        #1;
    endtask

    // Compare every output once the new inputs have settled
    task automatic verify();
        region_t    r;
        logic       ram_sel;
        logic [1:0] we;
        logic [7:0] mmr;
        #1;
        r       = region_of(cpu_addr[23:16]);
        ram_sel = cpu_as && r == REG_RAM;
        we[1]   = ram_sel && !cpu_rnw && !cpu_dsn[1];
        we[0]   = ram_sel && !cpu_rnw && !cpu_dsn[0];
        if (r == REG_PAIR) begin
            mmr = m_reply;
        end else if (r == REG_VTIM) begin
            mmr = cpu_addr[1] ? {6'd0, m_lvbl, m_irq} : 8'(m_v);
        end else begin
            mmr = 8'd0;
        end
        compare("rom_cs", int'(cpu_as && r == REG_ROM), int'(rom_cs));
        compare("ram_cs", int'(ram_sel), int'(ram_cs));
        compare("ram_we", int'(we), int'(ram_we));
        compare("ram_ok", int'(m_ram_ok), int'(ram_ok));
        compare("mmr_dout", int'(mmr), int'(mmr_dout));
        compare("snd_dout", int'(m_latch[snd_addr]), int'(snd_dout));
        compare("snd_irq", int'(m_snd_irq), int'(snd_irq));
        compare("pxl_cen", int'(m_pxl), int'(pxl_cen));
        compare("hdump", m_h, int'(hdump));
        compare("vdump", m_v, int'(vdump));
        compare("lhbl", int'(m_lhbl), int'(lhbl));
        compare("lvbl", int'(m_lvbl), int'(lvbl));
        compare("hs", int'(m_hs), int'(hs));
        compare("vs", int'(m_vs), int'(vs));
        compare("line_irq", int'(m_irq), int'(line_irq));
        if (pxl_cen) begin
            if (gap_valid) begin
                compare("pxl_cen_period", CEN_DIV, cen_gap);
            end
            gap_valid = 1'b1;
            cen_gap   = 0;
        end
        cen_gap++;
    endtask

    task automatic apply_reset();
        arst_n     = 1'b0;
        m_cen      = 0;
        m_h        = 0;
        m_v        = 0;
        m_pxl      = 1'b0;
        m_lhbl     = 1'b1;
        m_lvbl     = 1'b1;
        m_hs       = 1'b0;
        m_vs       = 1'b0;
        m_irq      = 1'b0;
        m_line     = 8'd0;
        m_as_l     = 1'b0;
        m_ram_ok   = 1'b0;
        m_latch[0] = 8'd0;
        m_latch[1] = 8'd0;
        m_reply    = 8'd0;
        m_snd_irq  = 1'b0;
        gap_valid  = 1'b0;
        cen_gap    = 0;
        repeat (3) @(posedge clk48);
        #1;
        arst_n = 1'b1;
    endtask

    task automatic run_decode();
        snd_rd = 1'b0;
        snd_we = 1'b0;
        repeat (DEC_LEN) begin
            tick();
            cpu_addr = {rand_page(), 7'd0, rand_byte()};
            cpu_dout = {rand_byte(), rand_byte()};
            cpu_rnw  = rand_bit();
            cpu_dsn  = {rand_bit(), rand_bit()};
            cpu_as   = rand_bit();
            verify();
        end
    endtask

    task automatic run_sound();
        repeat (SND_LEN) begin
            tick();
            cpu_addr = {PAIR_PAGE, 14'd0, rand_bit()};
            cpu_dout = {rand_byte(), rand_byte()};
            cpu_rnw  = rand_bit();
            cpu_dsn  = {rand_bit(), rand_bit()};
            cpu_as   = rand_bit();
            snd_addr = rand_bit();
            snd_rd   = rand_bit();
            snd_we   = rand_bit();
            snd_din  = rand_byte();
            verify();
        end
    endtask

    // One long bus cycle with data changing while cpu_as stays high
    task automatic hold_write(input logic sel);
        logic [7:0] first;
        // Idle cycle so the access starts from cpu_as low
        tick();
        cpu_as = 1'b0;
        snd_rd = 1'b0;
        snd_we = 1'b0;
        verify();
        tick();
        first    = rand_byte();
        cpu_addr = {PAIR_PAGE, 14'd0, sel};
        cpu_dout = {first, rand_byte()};
        cpu_rnw  = 1'b0;
        cpu_dsn  = 2'b00;
        cpu_as   = 1'b1;
        snd_addr = 1'b0;
        snd_rd   = 1'b0;
        snd_we   = 1'b0;
        verify();
        for (int i = 0; i < 5; i++) begin
            tick();
            cpu_dout = {rand_byte(), rand_byte()};
            snd_rd   = i == 1;
            verify();
        end
        tick();
        cpu_as   = 1'b0;
        snd_rd   = 1'b0;
        snd_addr = sel;
        verify();
        compare("hold_latch", int'(first), int'(snd_dout));
        compare("hold_irq", 0, int'(snd_irq));
    endtask

    task automatic run_video();
        cpu_as = 1'b0;
        snd_rd = 1'b0;
        snd_we = 1'b0;
        apply_reset();
        repeat (2 * FRAME) begin
            tick();
            verify();
        end
    endtask

    task automatic run_line_irq();
        logic [4:0] a;
        logic [7:0] ln;
        repeat (LINE_LEN) begin
            tick();
            a        = {rand_bit(), rand_bit(), rand_bit(), rand_bit(), rand_bit()};
            ln       = 8'(int'(rand_byte()) % V_TOTAL);
            cpu_addr = {VTIM_PAGE, 14'd0, rand_bit()};
            cpu_dout = {ln, rand_byte()};
            cpu_rnw  = 1'b1;
            cpu_dsn  = 2'b00;
            cpu_as   = rand_bit();
            if (a == 5'd0) begin
                cpu_addr[1] = VTIM_OFS_LINE;
                cpu_rnw     = 1'b0;
                cpu_as      = 1'b1;
            end else if (a == 5'd1) begin
                cpu_addr[1] = VTIM_OFS_ACK;
                cpu_rnw     = 1'b0;
                cpu_as      = 1'b1;
            end
            verify();
        end
    endtask

    initial begin
        lfsr     = 16'd9;
        cpu_addr = '0;
        cpu_dout = 16'd0;
        cpu_rnw  = 1'b1;
        cpu_dsn  = 2'b11;
        cpu_as   = 1'b0;
        snd_addr = 1'b0;
        snd_rd   = 1'b0;
        snd_we   = 1'b0;
        snd_din  = 8'd0;
        apply_reset();
        run_decode();
        run_sound();
        for (int i = 0; i < 4; i++) begin
            hold_write(i[0]);
        end
        run_video();
        run_line_irq();
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/rg_game.sv
// ----------------------------------------------------------
// Game glue top level
// Main bus decoder, sound CPU mailbox and video timer
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module rg_game import rg_pkg::*; #(
    parameter int CEN_DIV  = 8,
    parameter int H_TOTAL  = 384,
    parameter int H_VIS    = 288,
    parameter int HS_START = 304,
    parameter int HS_LEN   = 32,
    parameter int V_TOTAL  = 264,
    parameter int V_VIS    = 224,
    parameter int VS_START = 240,
    parameter int VS_LEN   = 8
) (
    input  wire logic              clk48,
    input  wire logic              arst_n,
    // main CPU bus
    input  wire logic [ADDR_W:1]   cpu_addr,
    input  wire logic [15:0]       cpu_dout,
    input  wire logic              cpu_rnw,
    input  wire logic [1:0]        cpu_dsn,
    input  wire logic              cpu_as,
    output logic                   rom_cs,
    output logic                   ram_cs,
    output logic [1:0]             ram_we,
    output logic                   ram_ok,
    output logic [BYTE_W-1:0]      mmr_dout,
    // sound CPU
    input  wire logic              snd_addr,
    input  wire logic              snd_rd,
    input  wire logic              snd_we,
    input  wire logic [BYTE_W-1:0] snd_din,
    output logic [BYTE_W-1:0]      snd_dout,
    output logic                   snd_irq,
    // video
    output logic                   pxl_cen,
    output logic [8:0]             hdump,
    output logic [8:0]             vdump,
    output logic                   lhbl,
    output logic                   lvbl,
    output logic                   hs,
    output logic                   vs,
    output logic                   line_irq
);

    logic              pair_wr;
    logic              vtim_wr;
    logic [BYTE_W-1:0] pair_dout;
    logic [BYTE_W-1:0] vtim_dout;

    rg_bus_decode u_decode (
        .clk48     ( clk48     ),
        .arst_n    ( arst_n    ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_rnw   ( cpu_rnw   ),
        .cpu_dsn   ( cpu_dsn   ),
        .cpu_as    ( cpu_as    ),
        .pair_dout ( pair_dout ),
        .vtim_dout ( vtim_dout ),
        .rom_cs    ( rom_cs    ),
        .ram_cs    ( ram_cs    ),
        .ram_we    ( ram_we    ),
        .ram_ok    ( ram_ok    ),
        .pair_wr   ( pair_wr   ),
        .vtim_wr   ( vtim_wr   ),
        .mmr_dout  ( mmr_dout  )
    );

    // Register blocks take the upper data byte
    rg_sound_pair u_pair (
        .clk48     ( clk48          ),
        .arst_n    ( arst_n         ),
        .pair_wr   ( pair_wr        ),
        .main_sel  ( cpu_addr[1]    ),
        .main_din  ( cpu_dout[15:8] ),
        .pair_dout ( pair_dout      ),
        .snd_addr  ( snd_addr       ),
        .snd_rd    ( snd_rd         ),
        .snd_we    ( snd_we         ),
        .snd_din   ( snd_din        ),
        .snd_dout  ( snd_dout       ),
        .snd_irq   ( snd_irq        )
    );

    rg_video_timer #(
        .CEN_DIV   ( CEN_DIV  ),
        .H_TOTAL   ( H_TOTAL  ),
        .H_VIS     ( H_VIS    ),
        .HS_START  ( HS_START ),
        .HS_LEN    ( HS_LEN   ),
        .V_TOTAL   ( V_TOTAL  ),
        .V_VIS     ( V_VIS    ),
        .VS_START  ( VS_START ),
        .VS_LEN    ( VS_LEN   )
    ) u_vtimer (
        .clk48     ( clk48          ),
        .arst_n    ( arst_n         ),
        .vtim_wr   ( vtim_wr        ),
        .reg_sel   ( cpu_addr[1]    ),
        .cpu_din   ( cpu_dout[15:8] ),
        .vtim_dout ( vtim_dout      ),
        .pxl_cen   ( pxl_cen        ),
        .hdump     ( hdump          ),
        .vdump     ( vdump          ),
        .lhbl      ( lhbl           ),
        .lvbl      ( lvbl           ),
        .hs        ( hs             ),
        .vs        ( vs             ),
        .line_irq  ( line_irq       )
    );

endmodule

`default_nettype wire

//--- hdl/rg_video_timer.sv
// ----------------------------------------------------------
// Video timer
// Pixel clock enable, horizontal and vertical counters
// Blanking and sync, programmable line interrupt registers
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module rg_video_timer import rg_pkg::*; #(
    parameter int CEN_DIV  = 8,
    parameter int H_TOTAL  = 384,
    parameter int H_VIS    = 288,
    parameter int HS_START = 304,
    parameter int HS_LEN   = 32,
    parameter int V_TOTAL  = 264,
    parameter int V_VIS    = 224,
    parameter int VS_START = 240,
    parameter int VS_LEN   = 8
) (
    input  wire logic              clk48,
    input  wire logic              arst_n,
    // CPU register access
    input  wire logic              vtim_wr,
    input  wire logic              reg_sel,
    input  wire logic [BYTE_W-1:0] cpu_din,
    output logic [BYTE_W-1:0]      vtim_dout,
    // video timing
    output logic                   pxl_cen,
    output logic [8:0]             hdump,
    output logic [8:0]             vdump,
    output logic                   lhbl,
    output logic                   lvbl,
    output logic                   hs,
    output logic                   vs,
    output logic                   line_irq
);

    localparam int CW = $clog2(CEN_DIV + 1);

    logic [CW-1:0]     cen_cnt;
    logic [8:0]        hnext;
    logic [8:0]        vnext;
    logic              hwrap;
    logic [BYTE_W-1:0] irq_line;
    logic              line_hit;

    // Pixel enable, one clk48 pulse every CEN_DIV cycles
    always_ff @(posedge clk48 or negedge arst_n) begin
        if (!arst_n) begin
            cen_cnt <= '0;
            pxl_cen <= 1'b0;
        end else begin
            pxl_cen <= cen_cnt == CW'(CEN_DIV - 1);
            cen_cnt <= (cen_cnt == CW'(CEN_DIV - 1)) ? '0 : cen_cnt + 1'b1;
        end
    end

    assign hwrap = hdump == 9'(H_TOTAL - 1);
    assign hnext = hwrap ? 9'd0 : hdump + 9'd1;
    always_comb begin
        if (!hwrap) begin
            vnext = vdump;
        end else if (vdump == 9'(V_TOTAL - 1)) begin
            vnext = 9'd0;
        end else begin
            vnext = vdump + 9'd1;
        end
    end

    // Windows computed from the next position so they line up with the counters
    always_ff @(posedge clk48 or negedge arst_n) begin
        if (!arst_n) begin
            hdump <= 9'd0;
            vdump <= 9'd0;
            lhbl  <= 1'b1;
            lvbl  <= 1'b1;
            hs    <= 1'b0;
            vs    <= 1'b0;
        end else if (pxl_cen) begin
            hdump <= hnext;
            vdump <= vnext;
            lhbl  <= hnext < H_VIS;
            lvbl  <= vnext < V_VIS;
            hs    <= hnext >= HS_START && hnext < HS_START + HS_LEN;
            vs    <= vnext >= VS_START && vnext < VS_START + VS_LEN;
        end
    end

    // Line match only when vdump actually moves onto the programmed line
    assign line_hit = pxl_cen && hwrap && vnext == {1'b0, irq_line};

    always_ff @(posedge clk48 or negedge arst_n) begin
        if (!arst_n) begin
            irq_line <= '0;
            line_irq <= 1'b0;
        end else begin
            if (vtim_wr && reg_sel == VTIM_OFS_LINE) begin
                irq_line <= cpu_din;
            end
            if (line_hit) begin
                line_irq <= 1'b1;
            end else if (vtim_wr && reg_sel == VTIM_OFS_ACK) begin
                line_irq <= 1'b0;
            end
        end
    end

    // Status byte: bit 0 irq, bit 1 lvbl
    assign vtim_dout = (reg_sel == VTIM_OFS_LINE) ? vdump[BYTE_W-1:0]
                                                  : {6'd0, lvbl, line_irq};

endmodule

`default_nettype wire

//--- hdl/rg_sound_pair.sv
// ----------------------------------------------------------
// Main to sound CPU mailbox
// Two command latches written by the main CPU
// Reply byte written by the sound CPU, sound interrupt
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module rg_sound_pair import rg_pkg::*; (
    input  wire logic              clk48,
    input  wire logic              arst_n,
    // main CPU side
    input  wire logic              pair_wr,
    input  wire logic              main_sel,
    input  wire logic [BYTE_W-1:0] main_din,
    output logic [BYTE_W-1:0]      pair_dout,
    // sound CPU side
    input  wire logic              snd_addr,
    input  wire logic              snd_rd,
    input  wire logic              snd_we,
    input  wire logic [BYTE_W-1:0] snd_din,
    output logic [BYTE_W-1:0]      snd_dout,
    output logic                   snd_irq
);

    logic [BYTE_W-1:0] latch0;
    logic [BYTE_W-1:0] latch1;
    logic [BYTE_W-1:0] reply;

    always_ff @(posedge clk48 or negedge arst_n) begin
        if (!arst_n) begin
            latch0 <= '0;
            latch1 <= '0;
        end else if (pair_wr) begin
            if (main_sel) begin
                latch1 <= main_din;
            end else begin
                latch0 <= main_din;
            end
        end
    end

    always_ff @(posedge clk48 or negedge arst_n) begin
        if (!arst_n) begin
            reply <= '0;
        end else if (snd_we) begin
            reply <= snd_din;
        end
    end

    // Latch 0 write raises the irq; sound reading latch 0 drops it
    // A write in the same cycle as the read keeps it raised
    always_ff @(posedge clk48 or negedge arst_n) begin
        if (!arst_n) begin
            snd_irq <= 1'b0;
        end else if (pair_wr && !main_sel) begin
            snd_irq <= 1'b1;
        end else if (snd_rd && !snd_addr) begin
            snd_irq <= 1'b0;
        end
    end

    assign snd_dout  = snd_addr ? latch1 : latch0;
    assign pair_dout = reply;

endmodule

`default_nettype wire

//--- hdl/rg_bus_decode.sv
// ----------------------------------------------------------
// Main CPU bus decoder
// Region decode, chip selects and RAM byte write enables
// RAM ready delay, register write pulses, register read mux
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module rg_bus_decode import rg_pkg::*; (
    input  wire logic              clk48,
    input  wire logic              arst_n,
    input  wire logic [ADDR_W:1]   cpu_addr,
    input  wire logic              cpu_rnw,
    input  wire logic [1:0]        cpu_dsn,
    input  wire logic              cpu_as,
    input  wire logic [BYTE_W-1:0] pair_dout,
    input  wire logic [BYTE_W-1:0] vtim_dout,
    output logic                   rom_cs,
    output logic                   ram_cs,
    output logic [1:0]             ram_we,
    output logic                   ram_ok,
    output logic                   pair_wr,
    output logic                   vtim_wr,
    output logic [BYTE_W-1:0]      mmr_dout
);

    region_t    region;
    logic [7:0] page;
    logic       as_l;
    logic       reg_wr;

    assign page = cpu_addr[23:16];

    always_comb begin
        if (page <= ROM_TOP) begin
            region = REG_ROM;
        end else if (page == RAM_PAGE) begin
            region = REG_RAM;
        end else if (page == VTIM_PAGE) begin
            region = REG_VTIM;
        end else if (page == PAIR_PAGE) begin
            region = REG_PAIR;
        end else begin
            region = REG_NONE;
        end
    end

    assign rom_cs = cpu_as && region == REG_ROM;
    assign ram_cs = cpu_as && region == REG_RAM;

    // dsn is active low, bit 1 is the upper byte
    assign ram_we = {2{ram_cs & ~cpu_rnw}} & ~cpu_dsn;

    // Only the first cycle of a bus cycle counts as a register write
    assign reg_wr  = cpu_as && !as_l && !cpu_rnw && !cpu_dsn[1];
    assign pair_wr = reg_wr && region == REG_PAIR;
    assign vtim_wr = reg_wr && region == REG_VTIM;

    always_ff @(posedge clk48 or negedge arst_n) begin
        if (!arst_n) begin
            as_l   <= 1'b0;
            ram_ok <= 1'b0;
        end else begin
            as_l   <= cpu_as;
            ram_ok <= ram_cs;
        end
    end

    always_comb begin
        case (region)
            REG_PAIR: mmr_dout = pair_dout;
            REG_VTIM: mmr_dout = vtim_dout;
            default:  mmr_dout = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/rg_pkg.sv
// ----------------------------------------------------------
// Shared definitions for the game glue logic
// Main CPU address map regions and page bytes
// Video timer register offsets, bus and data widths
// ----------------------------------------------------------
`default_nettype none

package rg_pkg;

    // Main address bus is cpu_addr[23:1]
    localparam int ADDR_W = 23;

    // Register data width
    localparam int BYTE_W = 8;

    // Region code from the upper address byte
    typedef enum logic [2:0] {
        REG_ROM  = 3'd0,
        REG_RAM  = 3'd1,
        REG_VTIM = 3'd2,
        REG_PAIR = 3'd3,
        REG_NONE = 3'd4
    } region_t;

    // ROM spans pages 00 to 1F
    localparam logic [7:0] ROM_TOP   = 8'h1F;
    localparam logic [7:0] RAM_PAGE  = 8'h20;
    localparam logic [7:0] VTIM_PAGE = 8'h38;
    localparam logic [7:0] PAIR_PAGE = 8'h3A;

    // Video timer registers, picked by cpu_addr[1]
    // Line register: write sets irq line, read gives current line
    localparam logic VTIM_OFS_LINE = 1'b0;
    // Ack register: write clears irq, read gives status
    localparam logic VTIM_OFS_ACK  = 1'b1;

endpackage

`default_nettype wire
